// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_dbg_port
RTL_TOP   ?= dbg_port_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/dbg_cmd_handler.sv ====
`timescale 1ns/1ps

module dbg_cmd_handler #(
    parameter int XLEN = 64
) (
    input  logic                           clk,
    input  logic                           rst,
    spi_byte_if.handler                    bus,
    dbg_ctrl_if.source                     ctrl,
    input  logic [XLEN-1:0]                core_pc,
    input  logic [dbg_pkg::ILEN-1:0]       core_instr,
    output logic [dbg_pkg::REG_SEL_W-1:0]  reg_sel,
    input  logic [XLEN-1:0]                reg_data
);

    localparam int XBYTES = XLEN / 8;
    localparam int IBYTES = dbg_pkg::ILEN / 8;
    localparam int CNT_W  = $clog2(XBYTES + 1);

    dbg_pkg::dbg_state_e state;

    logic [XLEN-1:0]  reply_buf;
    logic [CNT_W-1:0] reply_cnt;
    logic             shift_pending;

    //////////////////////////////////////////////////
    // Command decode and reply sequencing.
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= dbg_pkg::ST_IDLE;
            bus.tx_data     <= 8'h00;
            reply_cnt       <= '0;
            shift_pending   <= 1'b0;
            reg_sel         <= '0;
            ctrl.run_on     <= 1'b0;
            ctrl.run_off    <= 1'b0;
            ctrl.step       <= 1'b0;
            ctrl.led_toggle <= 1'b0;
        end else begin
            ctrl.run_on     <= 1'b0;
            ctrl.run_off    <= 1'b0;
            ctrl.step       <= 1'b0;
            ctrl.led_toggle <= 1'b0;

            // Advance the buffer once the slave holds the byte just sent.
            if (bus.tx_load && shift_pending) begin
                reply_buf     <= reply_buf << 8;
                shift_pending <= 1'b0;
            end

            case (state)
                dbg_pkg::ST_IDLE: begin
                    if (bus.rx_valid) begin
                        bus.tx_data <= 8'h00;
                        case (dbg_pkg::dbg_cmd_e'(bus.rx_data))
                            dbg_pkg::CMD_ECHO: begin
                                bus.tx_data <= 8'h01;
                                state       <= dbg_pkg::ST_ECHO;
                            end
                            dbg_pkg::CMD_TOGGLE_LED: ctrl.led_toggle <= 1'b1;
                            dbg_pkg::CMD_RUN:        ctrl.run_on     <= 1'b1;
                            dbg_pkg::CMD_HALT:       ctrl.run_off    <= 1'b1;
                            dbg_pkg::CMD_STEP:       ctrl.step       <= 1'b1;
                            dbg_pkg::CMD_GET_PC: begin
                                bus.tx_data <= 8'(XBYTES);
                                reply_buf   <= core_pc;
                                reply_cnt   <= CNT_W'(XBYTES);
                                state       <= dbg_pkg::ST_REPLYING;
                            end
                            dbg_pkg::CMD_GET_INSTR: begin
                                // Instruction sits in the top bytes so it leaves MSB first.
                                bus.tx_data <= 8'(IBYTES);
                                reply_buf   <= XLEN'(core_instr) << (XLEN - dbg_pkg::ILEN);
                                reply_cnt   <= CNT_W'(IBYTES);
                                state       <= dbg_pkg::ST_REPLYING;
                            end
                            dbg_pkg::CMD_GET_REG: state <= dbg_pkg::ST_REG_INDEX;
                            default: ;
                        endcase
                    end
                end

                dbg_pkg::ST_ECHO: begin
                    if (bus.rx_valid) begin
                        bus.tx_data <= bus.rx_data;
                        state       <= dbg_pkg::ST_IDLE;
                    end
                end

                dbg_pkg::ST_REG_INDEX: begin
                    if (bus.rx_valid) begin
                        reg_sel     <= bus.rx_data[dbg_pkg::REG_SEL_W-1:0];
                        bus.tx_data <= 8'(XBYTES);
                        state       <= dbg_pkg::ST_REG_LOAD;
                    end
                end

                // Register file answers the new index within this cycle.
                dbg_pkg::ST_REG_LOAD: begin
                    reply_buf <= reg_data;
                    reply_cnt <= CNT_W'(XBYTES);
                    state     <= dbg_pkg::ST_REPLYING;
                end

                dbg_pkg::ST_REPLYING: begin
                    if (bus.rx_valid) begin
                        bus.tx_data   <= reply_buf[XLEN-1 -: 8];
                        shift_pending <= 1'b1;
                        reply_cnt     <= reply_cnt - CNT_W'(1);
                        if (reply_cnt == CNT_W'(1)) begin
                            state <= dbg_pkg::ST_IDLE;
                        end
                    end
                end

                default: state <= dbg_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/dbg_ctrl_if.sv ====
`timescale 1ns/1ps

interface dbg_ctrl_if;

    // One-cycle strobes from the command handler.
    logic run_on;
    logic run_off;
    logic step;
    logic led_toggle;

    modport source (
        output run_on,
        output run_off,
        output step,
        output led_toggle
    );

    modport sink (
        input run_on,
        input run_off,
        input step,
        input led_toggle
    );

endinterface

// ==== hw/dbg_pkg.sv ====
package dbg_pkg;

    //////////////////////////////////////////////////
    // Widths shared between the debug port and the core.
    //////////////////////////////////////////////////

    // Instruction word width.
    localparam int ILEN = 32;

    // Integer register index width, 32 registers.
    localparam int REG_SEL_W = 5;

    //////////////////////////////////////////////////
    // Command codes, one byte each.
    //////////////////////////////////////////////////

    typedef enum logic [7:0] {
        CMD_NOP        = 8'h00,
        CMD_ECHO       = 8'h01,
        CMD_TOGGLE_LED = 8'h02,
        CMD_RUN        = 8'h03,
        CMD_HALT       = 8'h04,
        CMD_STEP       = 8'h05,
        CMD_GET_PC     = 8'h06,
        CMD_GET_INSTR  = 8'h07,
        CMD_GET_REG    = 8'h08
    } dbg_cmd_e;

    //////////////////////////////////////////////////
    // Command handler states.
    //////////////////////////////////////////////////

    // ST_ECHO waits for the byte to return.
    // ST_REG_INDEX waits for the register index byte.
    // ST_REG_LOAD captures the register value one cycle after the index.
    // ST_REPLYING sends buffered bytes, MSB first.
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ECHO,
        ST_REG_INDEX,
        ST_REG_LOAD,
        ST_REPLYING
    } dbg_state_e;

endpackage

// ==== hw/dbg_port_top.sv ====
`timescale 1ns/1ps

module dbg_port_top #(
    parameter int XLEN = 64
) (
    input  logic                           clk,
    input  logic                           rst,

    // SPI link to the host, mode 0.
    input  logic                           sclk,
    input  logic                           mosi,
    output logic                           miso,
    input  logic                           ss_n,

    output logic                           led,
    output logic                           core_clk_en,

    // Core observation.
    input  logic [XLEN-1:0]                core_pc,
    input  logic [dbg_pkg::ILEN-1:0]       core_instr,
    output logic [dbg_pkg::REG_SEL_W-1:0]  reg_sel,
    input  logic [XLEN-1:0]                reg_data
);

    spi_byte_if byte_bus ();
    dbg_ctrl_if ctrl_bus ();

    //////////////////////////////////////////////////
    // SPI byte slave.
    //////////////////////////////////////////////////

    spi_slave u_spi_slave (
        .clk  (clk),
        .rst  (rst),
        .sclk (sclk),
        .mosi (mosi),
        .ss_n (ss_n),
        .miso (miso),
        .bus  (byte_bus.slave)
    );

    //////////////////////////////////////////////////
    // Command handler.
    //////////////////////////////////////////////////

    dbg_cmd_handler #(
        .XLEN (XLEN)
    ) u_cmd_handler (
        .clk        (clk),
        .rst        (rst),
        .bus        (byte_bus.handler),
        .ctrl       (ctrl_bus.source),
        .core_pc    (core_pc),
        .core_instr (core_instr),
        .reg_sel    (reg_sel),
        .reg_data   (reg_data)
    );

    // LED and core run control.
    run_ctrl_regs u_run_ctrl (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl_bus.sink),
        .led         (led),
        .core_clk_en (core_clk_en)
    );

endmodule

// ==== hw/run_ctrl_regs.sv ====
`timescale 1ns/1ps

module run_ctrl_regs (
    input  logic      clk,
    input  logic      rst,
    dbg_ctrl_if.sink  ctrl,
    output logic      led,
    output logic      core_clk_en
);

    logic run_q;
    logic run_next;

    //////////////////////////////////////////////////
    // Run level and clock enable.
    //////////////////////////////////////////////////

    always_comb begin
        run_next = run_q;
        if (ctrl.run_on) begin
            run_next = 1'b1;
        end else if (ctrl.run_off) begin
            run_next = 1'b0;
        end
    end

    // A step adds one enabled cycle, invisible while already running.
    always_ff @(posedge clk) begin
        if (rst) begin
            run_q       <= 1'b0;
            core_clk_en <= 1'b0;
        end else begin
            run_q       <= run_next;
            core_clk_en <= run_next | ctrl.step;
        end
    end

    //////////////////////////////////////////////////
    // Indicator LED.
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            led <= 1'b0;
        end else if (ctrl.led_toggle) begin
            led <= ~led;
        end
    end

endmodule

// ==== hw/spi_byte_if.sv ====
`timescale 1ns/1ps

interface spi_byte_if;

    // Byte received from the host, valid with rx_valid.
    logic [7:0] rx_data;
    logic       rx_valid;

    // Byte to send during the next transfer.
    logic [7:0] tx_data;
    logic       tx_load;

    modport slave (
        output rx_data,
        output rx_valid,
        output tx_load,
        input  tx_data
    );

    modport handler (
        input  rx_data,
        input  rx_valid,
        input  tx_load,
        output tx_data
    );

endinterface

// ==== hw/spi_slave.sv ====
`timescale 1ns/1ps

module spi_slave (
    input  logic       clk,
    input  logic       rst,
    input  logic       sclk,
    input  logic       mosi,
    input  logic       ss_n,
    output logic       miso,
    spi_byte_if.slave  bus
);

    logic       sclk_meta;
    logic       sclk_sync;
    logic       sclk_prev;
    logic       mosi_meta;
    logic       mosi_sync;
    logic       ss_meta;
    logic       ss_sync;
    logic       ss_prev;

    logic       sclk_rise;
    logic       sclk_fall;
    logic       ss_fall;

    logic [2:0] bit_cnt;
    logic [7:0] rx_shift;
    logic [7:0] tx_shift;
    logic       rx_valid_q;
    logic [1:0] load_dly;

    //////////////////////////////////////////////////
    // Pin synchronizers and edge detection.
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            sclk_meta <= 1'b0;
            sclk_sync <= 1'b0;
            sclk_prev <= 1'b0;
            mosi_meta <= 1'b0;
            mosi_sync <= 1'b0;
            ss_meta   <= 1'b1;
            ss_sync   <= 1'b1;
            ss_prev   <= 1'b1;
        end else begin
            sclk_meta <= sclk;
            sclk_sync <= sclk_meta;
            sclk_prev <= sclk_sync;
            mosi_meta <= mosi;
            mosi_sync <= mosi_meta;
            ss_meta   <= ss_n;
            ss_sync   <= ss_meta;
            ss_prev   <= ss_sync;
        end
    end

    assign sclk_rise = sclk_sync & ~sclk_prev;
    assign sclk_fall = ~sclk_sync & sclk_prev;
    assign ss_fall   = ss_prev & ~ss_sync;

    //////////////////////////////////////////////////
    // Byte assembly and reply shifting.
    //////////////////////////////////////////////////

    // Next reply byte is taken at select or two cycles after a full byte.
    assign bus.tx_load = load_dly[1] | (ss_fall & (bit_cnt == 3'd0));

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt    <= 3'd0;
            tx_shift   <= 8'h00;
            rx_valid_q <= 1'b0;
            load_dly   <= 2'b00;
        end else begin
            rx_valid_q <= 1'b0;
            load_dly   <= {load_dly[0], rx_valid_q};

            if (ss_sync) begin
                bit_cnt <= 3'd0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_valid_q <= 1'b1;
                end
            end

            // The falling edge that closes a byte must not shift out the new reply.
            if (bus.tx_load) begin
                tx_shift <= bus.tx_data;
            end else if (sclk_fall && !ss_sync && bit_cnt != 3'd0) begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sclk_rise && !ss_sync) begin
            rx_shift <= {rx_shift[6:0], mosi_sync};
        end
    end

    assign bus.rx_data  = rx_shift;
    assign bus.rx_valid = rx_valid_q;
    assign miso         = tx_shift[7];

endmodule

// ==== testbench/tb_dbg_port.sv ====
`timescale 1ns/1ps

module tb_dbg_port;

    localparam int XLEN       = 64;
    localparam int XBYTES     = XLEN / 8;
    localparam int MAX_CYCLES = 300 * 12 * 90;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          sclk;
    logic                          mosi;
    logic                          miso;
    logic                          ss_n;
    logic                          led;
    logic                          core_clk_en;
    logic [XLEN-1:0]               core_pc;
    logic [dbg_pkg::ILEN-1:0]      core_instr;
    logic [dbg_pkg::REG_SEL_W-1:0] reg_sel;
    logic [XLEN-1:0]               reg_data = '0;

    // Core register file and the reply model.
    logic [XLEN-1:0]     regfile [32];
    dbg_pkg::dbg_state_e m_state;
    logic [7:0]          exp_reply;
    logic [7:0]          reply_q [$];
    logic                m_led;
    logic                m_run;

    int cycles     = 0;
    int en_cycles  = 0;
    int byte_cnt   = 0;
    int reply_errs = 0;
    int level_errs = 0;
    int step_errs  = 0;

    dbg_port_top #(
        .XLEN (XLEN)
    ) dut (
        .clk         (clk),
        .rst         (rst),
        .sclk        (sclk),
        .mosi        (mosi),
        .miso        (miso),
        .ss_n        (ss_n),
        .led         (led),
        .core_clk_en (core_clk_en),
        .core_pc     (core_pc),
        .core_instr  (core_instr),
        .reg_sel     (reg_sel),
        .reg_data    (reg_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (core_clk_en) begin
            en_cycles++;
        end
        if (cycles >= MAX_CYCLES) begin
            $display("Run stopped after %0d cycles before the tests finished.", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // Register read port of the core.
    always @(negedge clk) begin
        reg_data <= regfile[reg_sel];
    end

    //////////////////////////////////////////////////
    // SPI host and reply model.
    //////////////////////////////////////////////////

    // Mode 0, miso taken just before each rising sclk.
    task automatic spi_xfer(input logic [7:0] tx, output logic [7:0] rx);
        ss_n = 1'b0;
        mosi = tx[7];
        repeat (5) @(negedge clk);
        for (int i = 7; i >= 0; i--) begin
            rx[i] = miso;
            sclk  = 1'b1;
            repeat (5) @(negedge clk);
            sclk = 1'b0;
            if (i > 0) begin
                mosi = tx[i-1];
            end
            repeat (5) @(negedge clk);
        end
        ss_n = 1'b1;
        repeat (10) @(negedge clk);
    endtask

    task automatic model_update(input logic [7:0] b);
        logic [XLEN-1:0] word;
        word      = regfile[b[dbg_pkg::REG_SEL_W-1:0]];
        exp_reply = 8'h00;
        case (m_state)
            dbg_pkg::ST_IDLE: begin
                case (b)
                    dbg_pkg::CMD_ECHO: begin
                        exp_reply = 8'h01;
                        m_state   = dbg_pkg::ST_ECHO;
                    end
                    dbg_pkg::CMD_TOGGLE_LED: m_led = ~m_led;
                    dbg_pkg::CMD_RUN:        m_run = 1'b1;
                    dbg_pkg::CMD_HALT:       m_run = 1'b0;
                    dbg_pkg::CMD_GET_PC: begin
                        exp_reply = 8'(XBYTES);
                        for (int k = XBYTES - 1; k >= 0; k--) begin
                            reply_q.push_back(core_pc[8*k +: 8]);
                        end
                        m_state = dbg_pkg::ST_REPLYING;
                    end
                    dbg_pkg::CMD_GET_INSTR: begin
                        exp_reply = 8'h04;
                        for (int k = 3; k >= 0; k--) begin
                            reply_q.push_back(core_instr[8*k +: 8]);
                        end
                        m_state = dbg_pkg::ST_REPLYING;
                    end
                    dbg_pkg::CMD_GET_REG: m_state = dbg_pkg::ST_REG_INDEX;
                    default: ;
                endcase
            end
            dbg_pkg::ST_ECHO: begin
                exp_reply = b;
                m_state   = dbg_pkg::ST_IDLE;
            end
            dbg_pkg::ST_REG_INDEX: begin
                exp_reply = 8'(XBYTES);
                for (int k = XBYTES - 1; k >= 0; k--) begin
                    reply_q.push_back(word[8*k +: 8]);
                end
                m_state = dbg_pkg::ST_REPLYING;
            end
            default: begin
                exp_reply = reply_q.pop_front();
                if (reply_q.size() == 0) begin
                    m_state = dbg_pkg::ST_IDLE;
                end
            end
        endcase
    endtask

    // New core values each byte; the reply seen now belongs to the last byte.
    task automatic send_byte(input logic [7:0] b);
        logic [7:0] rx;
        core_pc    = XLEN'({$urandom, $urandom});
        core_instr = $urandom;
        spi_xfer(b, rx);
        if (rx !== exp_reply) begin
            $display("[FAIL] miso byte %0d: got %02h, expected %02h", byte_cnt, rx, exp_reply);
            reply_errs++;
        end
        model_update(b);
        byte_cnt++;
        if (led !== m_led) begin
            $display("[FAIL] led after byte %0d: got %0h, expected %0h", byte_cnt, led, m_led);
            level_errs++;
        end
        if (core_clk_en !== m_run) begin
            $display("[FAIL] core_clk_en after byte %0d: got %0h, expected %0h",
                     byte_cnt, core_clk_en, m_run);
            level_errs++;
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence.
    //////////////////////////////////////////////////

    initial begin
        int         n_steps;
        int         en_start;
        int         cyc_start;
        int         pick;
        logic [7:0] b;
        void'($urandom(32'hf4f6_0f2c));
        rst = 1'b1;
        sclk = 1'b0;
        mosi = 1'b0;
        ss_n = 1'b1;
        core_pc = '0;
        core_instr = '0;
        m_state = dbg_pkg::ST_IDLE;
        exp_reply = 8'h00;
        m_led = 1'b0;
        m_run = 1'b0;
        for (int r = 0; r < 32; r++) begin
            regfile[r] = XLEN'({$urandom, $urandom});
        end
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        if (miso !== 1'b0 || led !== 1'b0 || core_clk_en !== 1'b0) begin
            $display("[FAIL] outputs after reset: miso %0h, led %0h, core_clk_en %0h",
                     miso, led, core_clk_en);
            level_errs++;
        end
        send_byte(dbg_pkg::CMD_NOP);

        repeat (200) begin
            send_byte(dbg_pkg::CMD_ECHO);
            send_byte(8'($urandom));
        end

        repeat (4) send_byte(dbg_pkg::CMD_TOGGLE_LED);
        send_byte(dbg_pkg::CMD_RUN);
        // The enable stays high on every cycle while running.
        en_start  = en_cycles;
        cyc_start = cycles;
        repeat (3) send_byte(dbg_pkg::CMD_NOP);
        if (en_cycles - en_start != cycles - cyc_start) begin
            $display("[FAIL] core_clk_en while running: high %0h of %0h cycles",
                     en_cycles - en_start, cycles - cyc_start);
            level_errs++;
        end
        send_byte(dbg_pkg::CMD_HALT);
        en_start = en_cycles;
        n_steps  = 5 + int'($urandom % 4);
        repeat (n_steps) send_byte(dbg_pkg::CMD_STEP);
        if (en_cycles - en_start != n_steps) begin
            $display("[FAIL] core_clk_en cycles: got %0h, expected %0h",
                     en_cycles - en_start, n_steps);
            step_errs++;
        end
        // Steps while running leave the enable high.
        send_byte(dbg_pkg::CMD_RUN);
        send_byte(dbg_pkg::CMD_STEP);
        send_byte(dbg_pkg::CMD_HALT);

        repeat (16) begin
            send_byte(dbg_pkg::CMD_GET_PC);
            repeat (XBYTES) send_byte(8'($urandom));
            send_byte(dbg_pkg::CMD_GET_INSTR);
            repeat (4) send_byte(8'($urandom));
        end

        repeat (32) begin
            b = 8'($urandom);
            send_byte(dbg_pkg::CMD_GET_REG);
            send_byte(b);
            if (reg_sel !== b[dbg_pkg::REG_SEL_W-1:0]) begin
                $display("[FAIL] reg_sel: got %02h, expected %02h", reg_sel, b[4:0]);
                reply_errs++;
            end
            repeat (XBYTES) send_byte(8'($urandom));
        end

        // Mixed stream with known codes, unknown codes and raw bytes.
        repeat (400) begin
            pick = int'($urandom % 10);
            if (pick < 6) begin
                b = 8'($urandom % 9);
            end else if (pick < 8) begin
                b = 8'(9 + $urandom % 247);
            end else begin
                b = 8'($urandom);
            end
            send_byte(b);
        end
        while (m_state != dbg_pkg::ST_IDLE) begin
            send_byte(dbg_pkg::CMD_NOP);
        end
        send_byte(dbg_pkg::CMD_NOP);

        $display("Bytes %0d, reply errors %0d, level errors %0d, step errors %0d",
                 byte_cnt, reply_errs, level_errs, step_errs);
        if (reply_errs + level_errs + step_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/dbg_pkg.sv
hw/spi_byte_if.sv
hw/dbg_ctrl_if.sv
hw/spi_slave.sv
hw/dbg_cmd_handler.sv
hw/run_ctrl_regs.sv
hw/dbg_port_top.sv
testbench/tb_dbg_port.sv
